/* Makefile */
TOP = icache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* rtl/beat_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module beat_counter (
    input  wire                                      CLK,
    input  wire                                      rst_n,
    input  wire                                      fill_enb,            // Ready to L2
    input  wire                                      data_from_l2_valid,
    output logic [l2_bus_pkg::BEAT_IDX_WIDTH-1:0]    beat_idx,
    output logic                                     line_done
);

    logic [l2_bus_pkg::BEAT_IDX_WIDTH-1:0] beat_q;
    logic                                  accept;      // Handshake on the data channel
    logic                                  last_beat;

    assign accept    = fill_enb & data_from_l2_valid;
    assign last_beat = (beat_q == l2_bus_pkg::BEAT_LAST);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            beat_q <= '0;
        end else if (accept) begin
            beat_q <= last_beat ? '0 : beat_q + 1'b1;   // Wrap for the next line
        end
    end

    assign beat_idx  = beat_q;
    assign line_done = accept & last_beat;   // Same clock as the fourth beat

endmodule

`default_nettype wire

/* rtl/fetch_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_pipeline (
    input  wire                                CLK,
    input  wire                                rst_n,
    input  wire                                proc_ready,     // Level from processor
    input  wire                                branch,         // Held until taken
    input  wire  [icache_pkg::ADDR_WIDTH-1:0]  branch_addr,
    input  wire                                pipe_enb,       // Run state only
    input  wire  icache_pkg::pc_sel_e          pc_sel,
    input  wire                                hit,
    input  wire  [icache_pkg::WORD_WIDTH-1:0]  word,
    output icache_pkg::fetch_addr_t            read_addr,      // To both memories
    output icache_pkg::fetch_addr_t            lookup_addr,
    output logic                               lookup_miss,
    output logic                               instr_valid,
    output logic [icache_pkg::WORD_WIDTH-1:0]  instr,
    output logic [icache_pkg::ADDR_WIDTH-1:0]  instr_pc
);

    icache_pkg::fetch_addr_t pc;
    icache_pkg::fetch_addr_t pc_next;
    icache_pkg::pc_sel_e     sel;              // Select after branch override
    logic                    lookup_valid;
    logic                    lookup_pending;   // Lookup item missed
    logic                    branch_take;
    logic                    advance;          // PC moves into lookup
    logic                    deliver;

    assign branch_take    = branch & proc_ready & pipe_enb;    // cache_ready is the run state
    assign lookup_pending = lookup_valid & ~hit;
    assign advance        = branch_take | (pipe_enb & proc_ready & ~lookup_pending);
    assign lookup_miss    = pipe_enb & lookup_pending & ~branch_take;  // Branch kills it
    assign deliver        = pipe_enb & lookup_valid & hit & ~branch_take;
    assign sel            = branch_take ? icache_pkg::PC_BRANCH : pc_sel;

    // Memories re-read the lookup address while stalled
    assign read_addr = advance ? pc : lookup_addr;

    always_comb begin
        case (sel)
            icache_pkg::PC_BRANCH: pc_next = icache_pkg::fetch_addr_t'(branch_addr);
            icache_pkg::PC_REPLAY: pc_next = lookup_addr;          // Missed address again
            default:               pc_next = icache_pkg::fetch_addr_t'(pc + icache_pkg::PC_STEP);
        endcase
    end

    ////////////////////////////////////////////////////////////
    // PC and lookup stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pc           <= '0;                  // Fetch starts at 0
            lookup_addr  <= '0;
            lookup_valid <= 1'b0;
        end else if (sel == icache_pkg::PC_REPLAY) begin
            if (proc_ready) begin              // Replay waits for the processor
                pc           <= pc_next;
                lookup_valid <= 1'b0;          // Missed item leaves the stage
            end
        end else if (advance) begin
            pc           <= pc_next;
            lookup_addr  <= pc;
            lookup_valid <= ~branch_take;      // Wrong path entry squashed
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            instr_valid <= 1'b0;
        end else if (proc_ready) begin
            instr_valid <= deliver;
        end
    end

    always_ff @(posedge CLK) begin
        if (proc_ready && deliver) begin
            instr    <= word;
            instr_pc <= lookup_addr;
        end
    end

    // Output and both fetch stages frozen under processor back-pressure
    output_hold_a: assert property (@(posedge CLK) disable iff (!rst_n)
        !proc_ready |=> $stable(instr_valid) && (!instr_valid || $stable(instr))
                        && $stable(pc) && $stable(lookup_addr) && $stable(lookup_valid));

endmodule

`default_nettype wire

/* rtl/icache_arrays.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_arrays (
    input  wire                                CLK,
    input  wire                                rst_n,
    input  wire  icache_pkg::fetch_addr_t      read_addr,    // Next lookup address
    input  wire  icache_pkg::fetch_addr_t      lookup_addr,  // Address now in lookup
    input  wire  l2_bus_pkg::line_write_t      line_write,
    input  wire                                fill_enb,     // Accepted beat this clock
    output logic                               hit,
    output logic [icache_pkg::WORD_WIDTH-1:0]  word
);

    localparam int W = icache_pkg::WORD_WIDTH;

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    logic [icache_pkg::TAG_WIDTH-1:0] tag_mem [icache_pkg::NUM_LINES];
    logic [icache_pkg::NUM_LINES-1:0] valid_bits;                      // Cleared on reset
    l2_bus_pkg::l2_beat_t             line_mem [l2_bus_pkg::LINE_MEM_DEPTH];

    logic [$clog2(l2_bus_pkg::LINE_MEM_DEPTH)-1:0] line_rd_idx;
    logic [$clog2(l2_bus_pkg::LINE_MEM_DEPTH)-1:0] line_wr_idx;
    logic                                          tag_we;

    logic [icache_pkg::TAG_WIDTH-1:0] tag_q;      // Registered read data
    logic                             valid_q;
    l2_bus_pkg::l2_beat_t             line_q;

    // Line memory entry is {index, beat} with beat from the upper word offset bits
    assign line_rd_idx = {read_addr.index,
                          read_addr.word[icache_pkg::WORD_OFFSET_WIDTH-1 -:
                                         l2_bus_pkg::BEAT_IDX_WIDTH]};
    assign line_wr_idx = {line_write.index, line_write.beat};
    assign tag_we      = fill_enb & line_write.last;   // Tag goes in with the last beat

    ////////////////////////////////////////////////////////////
    // Writes and synchronous reads
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (fill_enb) begin
            line_mem[line_wr_idx] <= line_write.data;
        end
        if (tag_we) begin
            tag_mem[line_write.index] <= lookup_addr.tag;   // Lookup holds the missed address
        end
        line_q <= line_mem[line_rd_idx];
        tag_q  <= tag_mem[read_addr.index];
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            valid_bits <= '0;
            valid_q    <= 1'b0;
        end else begin
            if (tag_we) begin
                valid_bits[line_write.index] <= 1'b1;
            end
            valid_q <= valid_bits[read_addr.index];
        end
    end

    // Tag compare and word half select
    assign hit  = valid_q & (tag_q == lookup_addr.tag);
    assign word = lookup_addr.word[0] ? line_q[2*W-1 -: W] : line_q[W-1:0];

    // Last flag only arrives with an accepted final beat
    tag_write_a: assert property (@(posedge CLK) disable iff (!rst_n)
        line_write.last |-> fill_enb && line_write.beat == l2_bus_pkg::BEAT_LAST);

endmodule

`default_nettype wire

/* rtl/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    ////////////////////////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////////////////////////

    localparam int ADDR_WIDTH        = 32;      // Byte address
    localparam int WORD_WIDTH        = 32;      // One instruction
    localparam int WORDS_PER_LINE    = 8;
    localparam int LINE_INDEX_WIDTH  = 6;       // 64 lines
    localparam int WORD_OFFSET_WIDTH = 3;
    localparam int BYTE_OFFSET_WIDTH = 2;
    localparam int TAG_WIDTH         = ADDR_WIDTH - LINE_INDEX_WIDTH
                                     - WORD_OFFSET_WIDTH - BYTE_OFFSET_WIDTH;
    localparam int NUM_LINES         = 1 << LINE_INDEX_WIDTH;

    localparam logic [ADDR_WIDTH-1:0] PC_STEP = 4;  // Sequential fetch stride

    // Byte address split into its cache fields
    typedef struct packed {
        logic [TAG_WIDTH-1:0]         tag;
        logic [LINE_INDEX_WIDTH-1:0]  index;
        logic [WORD_OFFSET_WIDTH-1:0] word;
        logic [BYTE_OFFSET_WIDTH-1:0] byte_off;
    } fetch_addr_t;

    // Line address sent to L2, 27 bits
    typedef struct packed {
        logic [TAG_WIDTH-1:0]        tag;
        logic [LINE_INDEX_WIDTH-1:0] index;
    } line_addr_t;

    ////////////////////////////////////////////////////////////
    // Control types
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {PC_NEXT, PC_BRANCH, PC_REPLAY} pc_sel_e;

    typedef enum logic [1:0] {ST_RUN, ST_REQUEST, ST_FILL, ST_REPLAY} refill_state_e;

endpackage

`default_nettype wire

/* rtl/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire                                CLK,
    input  wire                                rst_n,
    input  wire                                proc_ready,
    input  wire                                branch,
    input  wire  [icache_pkg::ADDR_WIDTH-1:0]  branch_addr,
    output logic                               cache_ready,
    output logic                               instr_valid,
    output logic [icache_pkg::WORD_WIDTH-1:0]  instr,
    output logic [icache_pkg::ADDR_WIDTH-1:0]  instr_pc,
    output logic                               addr_to_l2_valid,
    input  wire                                addr_to_l2_ready,
    output icache_pkg::line_addr_t             addr_to_l2,
    input  wire                                data_from_l2_valid,
    output logic                               data_from_l2_ready,
    input  wire  l2_bus_pkg::l2_beat_t         data_from_l2
);

    icache_pkg::fetch_addr_t                 read_addr;
    icache_pkg::fetch_addr_t                 lookup_addr;
    icache_pkg::pc_sel_e                     pc_sel;
    logic                                    lookup_miss;
    logic                                    hit;
    logic [icache_pkg::WORD_WIDTH-1:0]       word;
    logic                                    pipe_enb;
    logic                                    fill_enb;       // Fill state level
    logic [icache_pkg::LINE_INDEX_WIDTH-1:0] miss_index;
    logic [l2_bus_pkg::BEAT_IDX_WIDTH-1:0]   beat_idx;
    logic                                    line_done;
    wire                                     beat_write;     // Beat accepted from L2
    l2_bus_pkg::line_write_t                 line_write;

    assign beat_write = data_from_l2_valid & data_from_l2_ready;
    assign line_write = '{index: miss_index, beat: beat_idx, data: data_from_l2, last: line_done};

    fetch_pipeline u_fetch (
        .CLK, .rst_n, .proc_ready, .branch, .branch_addr, .pipe_enb, .pc_sel, .hit, .word,
        .read_addr, .lookup_addr, .lookup_miss, .instr_valid, .instr, .instr_pc
    );

    icache_arrays u_arrays (
        .CLK, .rst_n, .read_addr, .lookup_addr, .line_write,
        .fill_enb (beat_write),
        .hit, .word
    );

    refill_fsm u_fsm (
        .CLK, .rst_n, .proc_ready, .lookup_miss, .lookup_addr, .line_done, .addr_to_l2_ready,
        .addr_to_l2_valid, .addr_to_l2, .fill_enb, .data_from_l2_ready, .pipe_enb, .pc_sel,
        .cache_ready, .miss_index
    );

    beat_counter u_beats (
        .CLK, .rst_n, .fill_enb, .data_from_l2_valid, .beat_idx, .line_done
    );

endmodule

`default_nettype wire

/* rtl/l2_bus_pkg.sv */
`default_nettype none

package l2_bus_pkg;

    localparam int L2_BUS_WIDTH   = 64;
    localparam int WORDS_PER_BEAT = L2_BUS_WIDTH / icache_pkg::WORD_WIDTH;    // 2 words
    localparam int BEATS_PER_LINE = icache_pkg::WORDS_PER_LINE / WORDS_PER_BEAT;
    localparam int BEAT_IDX_WIDTH = $clog2(BEATS_PER_LINE);
    localparam int LINE_MEM_DEPTH = icache_pkg::NUM_LINES * BEATS_PER_LINE;  // One entry per beat

    localparam logic [BEAT_IDX_WIDTH-1:0] BEAT_LAST = BEAT_IDX_WIDTH'(BEATS_PER_LINE - 1);

    typedef logic [L2_BUS_WIDTH-1:0] l2_beat_t;    // Low word in low half

    // One beat headed for the line memory
    typedef struct packed {
        logic [icache_pkg::LINE_INDEX_WIDTH-1:0] index;
        logic [BEAT_IDX_WIDTH-1:0]               beat;
        l2_beat_t                                data;
        logic                                    last;     // Final beat of the line
    } line_write_t;

endpackage

`default_nettype wire

/* rtl/refill_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module refill_fsm (
    input  wire                                       CLK,
    input  wire                                       rst_n,
    input  wire                                       proc_ready,
    input  wire                                       lookup_miss,
    input  wire  icache_pkg::fetch_addr_t             lookup_addr,
    input  wire                                       line_done,        // Fourth beat taken
    input  wire                                       addr_to_l2_ready,
    output logic                                      addr_to_l2_valid,
    output icache_pkg::line_addr_t                    addr_to_l2,
    output logic                                      fill_enb,
    output logic                                      data_from_l2_ready,
    output logic                                      pipe_enb,
    output icache_pkg::pc_sel_e                       pc_sel,
    output logic                                      cache_ready,
    output logic [icache_pkg::LINE_INDEX_WIDTH-1:0]   miss_index
);

    icache_pkg::refill_state_e state;
    icache_pkg::line_addr_t    miss_line;    // Captured on the miss

    ////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state <= icache_pkg::ST_RUN;
        end else begin
            case (state)
                icache_pkg::ST_RUN:     if (lookup_miss)      state <= icache_pkg::ST_REQUEST;
                icache_pkg::ST_REQUEST: if (addr_to_l2_ready) state <= icache_pkg::ST_FILL;
                icache_pkg::ST_FILL:    if (line_done)        state <= icache_pkg::ST_REPLAY;
                icache_pkg::ST_REPLAY:  if (proc_ready)       state <= icache_pkg::ST_RUN;
                default:                                      state <= icache_pkg::ST_RUN;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == icache_pkg::ST_RUN && lookup_miss) begin
            miss_line.tag   <= lookup_addr.tag;
            miss_line.index <= lookup_addr.index;
        end
    end

    ////////////////////////////////////////////////////////////
    // Decoded outputs
    ////////////////////////////////////////////////////////////

    assign addr_to_l2_valid   = (state == icache_pkg::ST_REQUEST);
    assign addr_to_l2         = miss_line;
    assign fill_enb           = (state == icache_pkg::ST_FILL);
    assign data_from_l2_ready = fill_enb;                         // Always sink beats in fill
    assign pipe_enb           = (state == icache_pkg::ST_RUN);
    assign cache_ready        = pipe_enb;
    assign pc_sel             = (state == icache_pkg::ST_REPLAY) ? icache_pkg::PC_REPLAY
                                                                 : icache_pkg::PC_NEXT;
    assign miss_index         = miss_line.index;

    // L2 request and the missed lookup address held until accepted
    req_hold_a: assert property (@(posedge CLK) disable iff (!rst_n)
        addr_to_l2_valid && !addr_to_l2_ready |=> addr_to_l2_valid && $stable(addr_to_l2)
                                                  && $stable(lookup_addr));

    // Beat counter ends a line only during a fill
    done_in_fill_a: assert property (@(posedge CLK) disable iff (!rst_n)
        line_done |-> state == icache_pkg::ST_FILL);

endmodule

`default_nettype wire

/* tests/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam logic [31:0] WORD_KEY      = 32'hC0DE_5A5A;   // Word at A is A ^ WORD_KEY
    localparam int          TOTAL_FETCHES = 40 + 24 + 16 + 8 + 60;
    localparam int          WATCHDOG_CLKS = 16 + TOTAL_FETCHES * 40;   // Worst case per fetch

    logic                              CLK;
    logic                              rst_n;
    logic                              proc_ready;
    logic                              branch;
    logic [icache_pkg::ADDR_WIDTH-1:0] branch_addr;
    logic                              cache_ready;
    logic                              instr_valid;
    logic [icache_pkg::WORD_WIDTH-1:0] instr;
    logic [icache_pkg::ADDR_WIDTH-1:0] instr_pc;
    logic                              addr_to_l2_valid;
    logic                              addr_to_l2_ready;
    icache_pkg::line_addr_t            addr_to_l2;
    logic                              data_from_l2_valid;
    logic                              data_from_l2_ready;
    l2_bus_pkg::l2_beat_t              data_from_l2;

    int          num_checks = 0;
    int          num_errors = 0;
    int          delivered = 0;        // Processor side transfers
    int          req_count = 0;        // Accepted L2 requests
    int          branches_taken = 0;
    logic [31:0] exp_pc = '0;          // Next expected instruction address
    logic [31:0] last_pc = '0;
    logic        held_valid = 1'b0;    // Output was stalled last clock
    logic [31:0] held_instr = '0;
    logic [31:0] held_pc = '0;
    logic        gaps_on = 1'b0;       // Random proc_ready gaps
    int          l2_slack = 2;         // Max L2 delay in clocks
    logic [31:0] l2_seed = 32'd46;
    logic [31:0] ready_seed = 32'd46;
    icache_pkg::line_addr_t resident [icache_pkg::NUM_LINES];    // Lines L2 has sent per index
    logic [icache_pkg::NUM_LINES-1:0] resident_valid = '0;

    icache_top dut (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;    // 8 ns period
    end

    ////////////////////////////////////////////////////////////
    // Reference rules and helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] word_at(input logic [31:0] a);
        return a ^ WORD_KEY;
    endfunction

    function automatic icache_pkg::line_addr_t line_of(input logic [31:0] a);
        return icache_pkg::line_addr_t'(a[31:5]);    // 32 byte lines
    endfunction

    // Beat k holds words 2k and 2k+1, lower word in the low half
    function automatic l2_bus_pkg::l2_beat_t beat_data(input icache_pkg::line_addr_t line,
                                                       input int k);
        logic [31:0] a;
        a = {line, 5'b0} + 32'(8 * k);
        return {word_at(a + 32'd4), word_at(a)};
    endfunction

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int l2_delay();
        l2_seed = lcg_step(l2_seed);
        return int'(l2_seed[20:16]) % (l2_slack + 1);
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Request must be for the next expected line or its lookahead, and never repeated
    task automatic log_request();
        icache_pkg::line_addr_t want;
        want = line_of(exp_pc);
        if (addr_to_l2 == line_of(exp_pc + 32'd4))
            want = line_of(exp_pc + 32'd4);
        check_value("addr_to_l2", 64'(addr_to_l2), 64'(want));
        if (resident_valid[addr_to_l2.index] && resident[addr_to_l2.index] == addr_to_l2) begin
            num_errors++;
            $display("ERROR: L2 request repeated for line %h that should be cached", addr_to_l2);
        end
        resident[addr_to_l2.index]       = addr_to_l2;
        resident_valid[addr_to_l2.index] = 1'b1;
        req_count++;
    endtask

    ////////////////////////////////////////////////////////////
    // Monitor, sampled mid cycle
    ////////////////////////////////////////////////////////////

    always @(negedge CLK) begin : monitor
        if (rst_n) begin
            if (held_valid) begin                      // Output frozen by the stall
                check_value("instr_valid", 64'(instr_valid), 64'd1);
                check_value("instr", 64'(instr), 64'(held_instr));
                check_value("instr_pc", 64'(instr_pc), 64'(held_pc));
            end
            if (addr_to_l2_valid && addr_to_l2_ready)
                log_request();
            if (instr_valid && proc_ready) begin       // Transfer at the coming edge
                check_value("instr_pc", 64'(instr_pc), 64'(exp_pc));
                check_value("instr", 64'(instr), 64'(word_at(exp_pc)));
                last_pc = instr_pc;
                exp_pc  = exp_pc + 32'd4;
                delivered++;
            end
            if (branch && proc_ready && cache_ready) begin
                exp_pc = branch_addr;                  // Taken at the coming edge
                branches_taken++;
            end
            held_valid = instr_valid && !proc_ready;
            held_instr = instr;
            held_pc    = instr_pc;
        end
    end

    ////////////////////////////////////////////////////////////
    // L2 model and proc_ready driver
    ////////////////////////////////////////////////////////////

    initial begin : l2_model
        icache_pkg::line_addr_t req_line;
        int                     k;
        addr_to_l2_ready   = 1'b0;
        data_from_l2_valid = 1'b0;
        data_from_l2       = '0;
        forever begin
            @(posedge CLK);
            #1;
            if (rst_n && addr_to_l2_valid) begin
                repeat (l2_delay()) begin
                    @(posedge CLK);
                    #1;
                end
                req_line         = addr_to_l2;    // Stable until accepted
                addr_to_l2_ready = 1'b1;
                @(posedge CLK);
                #1;
                addr_to_l2_ready = 1'b0;
                for (k = 0; k < l2_bus_pkg::BEATS_PER_LINE; k++) begin
                    repeat (l2_delay()) begin
                        @(posedge CLK);
                        #1;
                    end
                    data_from_l2_valid = 1'b1;
                    data_from_l2       = beat_data(req_line, k);
                    while (!data_from_l2_ready) begin
                        @(posedge CLK);
                        #1;
                    end
                    @(posedge CLK);                // Beat accepted here
                    #1;
                    data_from_l2_valid = 1'b0;
                end
            end
        end
    end

    initial begin : ready_driver
        proc_ready = 1'b1;
        forever begin
            @(posedge CLK);
            #1;
            if (gaps_on) begin
                ready_seed = lcg_step(ready_seed);
                proc_ready = (ready_seed[17:16] != 2'b00);    // About one clock in four low
            end else begin
                proc_ready = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Test steps
    ////////////////////////////////////////////////////////////

    task automatic take_branch(input logic [31:0] target);
        int seen;
        seen = branches_taken;
        @(posedge CLK);
        #1;
        branch      = 1'b1;
        branch_addr = target;
        while (branches_taken == seen)
            @(posedge CLK);                      // Held until taken
        #1;
        branch = 1'b0;
    endtask

    task automatic wait_transfers(input int n);
        int target;
        target = delivered + n;
        while (delivered < target)
            @(posedge CLK);
    endtask

    task automatic report_test(input int n, input string name, input int err_mark);
        $display("Test %0d %s finished, %0d errors", n, name, num_errors - err_mark);
    endtask

    task automatic cold_fetch_test();
        int errs;
        errs = num_errors;
        wait_transfers(40);
        check_value("L2 requests", 64'(req_count), 64'd5);    // Lines 0 to 4
        report_test(1, "cold sequential fetch", errs);
    endtask

    task automatic hit_refetch_test();
        int errs;
        int reqs;
        errs = num_errors;
        take_branch(32'h0);
        reqs = req_count;
        wait_transfers(24);
        check_value("L2 requests", 64'(req_count - reqs), 64'd0);
        report_test(2, "hits without L2 traffic", errs);
    endtask

    task automatic branch_redirect_test();
        int errs;
        int reqs;
        errs = num_errors;
        take_branch(32'h30);                      // Mid line 1
        reqs = req_count;
        wait_transfers(6);
        take_branch(32'h94);                      // While streaming
        wait_transfers(1);
        check_value("instr_pc after branch", 64'(last_pc), 64'h94);
        wait_transfers(9);
        check_value("L2 requests", 64'(req_count - reqs), 64'd0);    // Lines 1, 2, 4, 5 cached
        report_test(3, "branch redirect", errs);
    endtask

    task automatic conflict_evict_test();
        int errs;
        int reqs;
        errs = num_errors;
        take_branch(32'h808);                     // Index 0, tag 1
        reqs = req_count;
        wait_transfers(4);
        take_branch(32'h8);                       // Index 0, tag 0 again
        wait_transfers(4);
        check_value("L2 requests", 64'(req_count - reqs), 64'd2);
        report_test(4, "conflict eviction", errs);
    endtask

    task automatic backpressure_test();
        int errs;
        int reqs;
        errs = num_errors;
        @(negedge CLK);
        gaps_on  = 1'b1;
        l2_slack = 6;
        take_branch(32'h100);
        reqs = req_count;
        wait_transfers(60);
        check_value("L2 requests", 64'(req_count - reqs), 64'd8);    // Lines 8 to 15
        @(negedge CLK);
        gaps_on  = 1'b0;
        l2_slack = 2;
        report_test(5, "back-pressure", errs);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin : main
        rst_n       = 1'b0;
        branch      = 1'b0;
        branch_addr = '0;
        repeat (16) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        @(negedge CLK);
        check_value("cache_ready", 64'(cache_ready), 64'd1);          // Run state
        check_value("instr_valid", 64'(instr_valid), 64'd0);
        check_value("addr_to_l2_valid", 64'(addr_to_l2_valid), 64'd0);
        check_value("data_from_l2_ready", 64'(data_from_l2_ready), 64'd0);
        cold_fetch_test();
        hit_refetch_test();
        branch_redirect_test();
        conflict_evict_test();
        backpressure_test();
        $display("Checks %0d, errors %0d, transfers %0d, L2 requests %0d",
                 num_checks, num_errors, delivered, req_count);
        if (num_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CLKS) @(posedge CLK);
        $display("Timeout after %0d clocks, the tests did not complete", WATCHDOG_CLKS);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rtl/icache_pkg.sv
rtl/l2_bus_pkg.sv
rtl/beat_counter.sv
rtl/refill_fsm.sv
rtl/icache_arrays.sv
rtl/fetch_pipeline.sv
rtl/icache_top.sv
tests/icache_tb.sv
